// ==== Bender.yml ====
package:
  name: fpu

sources:
  - files:
      - rtl/fpu_pkg.sv
      - rtl/fpu_latency_timer.sv
      - rtl/fpu_ctrl.sv
      - rtl/fpu_addsub.sv
      - rtl/fpu_mul.sv
      - rtl/fpu_misc.sv
      - rtl/fpu_top.sv
  - target: test
    files:
      - verification/fpu_clk_gen.sv
      - verification/fpu_checker.sv
      - verification/fpu_tb.sv

// ==== files.f ====
rtl/fpu_pkg.sv
rtl/fpu_latency_timer.sv
rtl/fpu_ctrl.sv
rtl/fpu_addsub.sv
rtl/fpu_mul.sv
rtl/fpu_misc.sv
rtl/fpu_top.sv
verification/fpu_clk_gen.sv
verification/fpu_checker.sv
verification/fpu_tb.sv

// ==== rtl/fpu_addsub.sv ====
////////////////////////////////////////
// FPU add/subtract, three-stage pipeline
// Truncating, subnormals flushed to zero
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_addsub (
    input  logic        clk,
    input  logic        rstn,
    input  logic        sub,
    input  logic [31:0] x1,
    input  logic [31:0] x2,
    output logic [31:0] y
);
    import fpu_pkg::*;

    ////////////////////////////////////////
    // Stage 1: order by magnitude, align
    ////////////////////////////////////////
    logic        sign2;
    logic        swap;
    logic [31:0] a;
    logic [31:0] b;
    logic [26:0] ma;
    logic [26:0] mb;
    logic [7:0]  diff;
    logic        sticky;

    // Mantissas carry hidden bit, 23 fraction bits and 3 guard bits
    always_comb begin
        sign2  = x2[31] ^ sub;
        swap   = x2[30:0] > x1[30:0];
        a      = swap ? {sign2, x2[30:0]} : x1;
        b      = swap ? x1 : {sign2, x2[30:0]};
        ma     = (a[30:23] != 8'd0) ? {1'b1, a[22:0], 3'b000} : 27'd0;
        mb     = (b[30:23] != 8'd0) ? {1'b1, b[22:0], 3'b000} : 27'd0;
        diff   = a[30:23] - b[30:23];
        sticky = |(mb & ~(27'h7ff_ffff << diff));
    end

    logic        s1_sign;
    logic        s1_zsign;
    logic        s1_eff_sub;
    logic [7:0]  s1_exp;
    logic [26:0] s1_ml;
    logic [26:0] s1_ms;

    always_ff @(posedge clk) begin
        s1_sign    <= a[31];
        s1_zsign   <= a[31] & b[31];
        s1_eff_sub <= a[31] ^ b[31];
        s1_exp     <= a[30:23];
        s1_ml      <= ma;
        s1_ms      <= (mb >> diff) | {26'd0, sticky};
    end

    ////////////////////////////////////////
    // Stage 2: mantissa add or subtract
    ////////////////////////////////////////
    logic        s2_sign;
    logic        s2_zsign;
    logic [7:0]  s2_exp;
    logic [27:0] s2_sum;

    always_ff @(posedge clk) begin
        s2_sign  <= s1_sign;
        s2_zsign <= s1_zsign;
        s2_exp   <= s1_exp;
        // Larger magnitude first, so the difference never goes negative
        s2_sum   <= s1_eff_sub ? ({1'b0, s1_ml} - {1'b0, s1_ms})
                               : ({1'b0, s1_ml} + {1'b0, s1_ms});
    end

    ////////////////////////////////////////
    // Stage 3: normalize, truncate, pack
    ////////////////////////////////////////
    logic [5:0]        lz;
    logic [26:0]       norm;
    logic signed [9:0] exp_n;

    always_comb begin
        lz = fpu_lzc({s2_sum[26:0], 5'd0});
        if (s2_sum[27]) begin
            norm  = s2_sum[27:1];
            exp_n = $signed({2'b00, s2_exp}) + 10'sd1;
        end else begin
            norm  = s2_sum[26:0] << lz;
            exp_n = $signed({2'b00, s2_exp}) - $signed({4'b0000, lz});
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            y <= '0;
        end else if (s2_sum == 28'd0) begin
            // Exact cancellation gives +0, only -0 + -0 stays negative
            y <= {s2_zsign, 31'd0};
        end else if (exp_n <= 0) begin
            y <= {s2_sign, 31'd0};
        end else if (exp_n >= 255) begin
            y <= {s2_sign, 8'hff, 23'd0};
        end else begin
            y <= {s2_sign, exp_n[7:0], norm[25:3]};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fpu_ctrl.sv ====
////////////////////////////////////////
// FPU control FSM
// Holds the request, times it, returns the result
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_ctrl #(
    parameter int CNT_W = 4
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    input  fpu_pkg::fpu_req_t  req,
    output logic               req_ready,
    output fpu_pkg::fpu_op_t   op,
    output logic [31:0]        src0,
    output logic [31:0]        src1,
    output logic               tmr_load,
    output logic [CNT_W-1:0]   tmr_count,
    input  logic               tmr_expire,
    input  logic [31:0]        addsub_res,
    input  logic [31:0]        mul_res,
    input  logic [31:0]        misc_res,
    output logic               resp_valid,
    output fpu_pkg::fpu_resp_t resp
);
    import fpu_pkg::*;

    typedef enum logic [1:0] {IDLE, BUSY, DONE} state_t;

    state_t      state;
    logic        accept;
    logic [31:0] sel_res;

    // DONE also takes a new request, so back-to-back issue loses no cycle
    assign req_ready  = (state != BUSY);
    assign accept     = req_valid && req_ready;
    assign resp_valid = (state == DONE);

    // Operand register feeding all datapaths
    always_ff @(posedge clk) begin
        if (accept) begin
            op   <= req.op;
            src0 <= req.src0;
            src1 <= req.src1;
        end
    end

    always_comb begin
        case (op)
            FADD, FSUB: sel_res = addsub_res;
            FMUL:       sel_res = mul_res;
            default:    sel_res = misc_res;
        endcase
    end

    ////////////////////////////////////////
    // State and timer load
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= IDLE;
            tmr_load  <= 1'b0;
            tmr_count <= '0;
            resp      <= '0;
        end else begin
            // Timer starts one cycle after accept, with the operands
            tmr_load <= accept;
            if (accept) begin
                tmr_count <= CNT_W'(fpu_latency(req.op));
            end
            case (state)
                BUSY: begin
                    if (tmr_expire) begin
                        state       <= DONE;
                        resp.result <= sel_res;
                    end
                end
                default: begin
                    state <= accept ? BUSY : IDLE;
                end
            endcase
        end
    end

    a_expire_in_busy: assert property (@(posedge clk) disable iff (!rstn)
        tmr_expire |-> state == BUSY);

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |=> !resp_valid);

endmodule

`default_nettype wire

// ==== rtl/fpu_latency_timer.sv ====
////////////////////////////////////////
// FPU latency timer
// Down-counter, expire pulse N cycles after load
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_latency_timer #(
    parameter int CNT_W = 4
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             load,
    input  logic [CNT_W-1:0] count,
    output logic             expire,
    output logic             running
);

    logic [CNT_W-1:0] cnt;

    // Count reaches zero N-1 edges after the load edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (load) begin
            cnt     <= count - 1'b1;
            running <= 1'b1;
        end else if (running) begin
            if (cnt == '0) begin
                running <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign expire = running && (cnt == '0);

    // Single issue, the controller waits for expire before reloading
    a_no_load_running: assert property (@(posedge clk) disable iff (!rstn)
        load |-> !running);

endmodule

`default_nettype wire

// ==== rtl/fpu_misc.sv ====
////////////////////////////////////////
// FPU sign injection, compare, convert
// Single registered stage
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_misc (
    input  logic             clk,
    input  logic             rstn,
    input  fpu_pkg::fpu_op_t op,
    input  logic [31:0]      x1,
    input  logic [31:0]      x2,
    output logic [31:0]      y
);
    import fpu_pkg::*;

    // Signed ordering key, both zeros map to 0
    function automatic logic signed [31:0] order_key(logic [31:0] v);
        logic [30:0] mag;
        mag = (v[30:23] == 8'd0) ? 31'd0 : v[30:0];
        return v[31] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
    endfunction

    logic        eq;
    logic        lt;
    logic [7:0]  e;
    logic [31:0] mant;
    logic [31:0] mag_w;
    logic [31:0] cvt_w;
    logic [31:0] mag_s;
    logic [5:0]  lz;
    logic [31:0] norm_s;
    logic [7:0]  exp_s;
    logic [31:0] cvt_s;
    logic [31:0] y_next;

    always_comb begin
        eq = order_key(x1) == order_key(x2);
        lt = order_key(x1) < order_key(x2);

        // Float to integer, truncated toward zero
        e     = x1[30:23];
        mant  = {8'd0, 1'b1, x1[22:0]};
        mag_w = (e >= 8'd150) ? (mant << (e - 8'd150)) : (mant >> (8'd150 - e));
        if (e < 8'd127) begin
            cvt_w = 32'd0;
        end else if (e >= 8'd158) begin
            cvt_w = x1[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end else begin
            cvt_w = x1[31] ? -mag_w : mag_w;
        end

        // Integer to float, low bits dropped
        mag_s  = x1[31] ? -x1 : x1;
        lz     = fpu_lzc(mag_s);
        norm_s = mag_s << lz;
        exp_s  = 8'd158 - {2'b00, lz};
        cvt_s  = (mag_s == 32'd0) ? 32'd0 : {x1[31], exp_s, norm_s[30:8]};

        case (op)
            FSGNJ:    y_next = {x2[31], x1[30:0]};
            FSGNJN:   y_next = {~x2[31], x1[30:0]};
            FSGNJX:   y_next = {x1[31] ^ x2[31], x1[30:0]};
            FEQ:      y_next = {31'd0, eq};
            FLE:      y_next = {31'd0, lt | eq};
            FLT:      y_next = {31'd0, lt};
            FCVT_W_S: y_next = cvt_w;
            FCVT_S_W: y_next = cvt_s;
            default:  y_next = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            y <= '0;
        end else begin
            y <= y_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fpu_mul.sv ====
////////////////////////////////////////
// FPU multiplier, three-stage pipeline
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_mul (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] x1,
    input  logic [31:0] x2,
    output logic [31:0] y
);

    ////////////////////////////////////////
    // Stage 1: sign, exponent sum, product
    ////////////////////////////////////////
    logic        s1_sign;
    logic        s1_zero;
    logic [9:0]  s1_exp;
    logic [47:0] s1_prod;

    always_ff @(posedge clk) begin
        s1_sign <= x1[31] ^ x2[31];
        // Zero and subnormal operands both count as zero
        s1_zero <= (x1[30:23] == 8'd0) || (x2[30:23] == 8'd0);
        s1_exp  <= {2'b00, x1[30:23]} + {2'b00, x2[30:23]};
        s1_prod <= {1'b1, x1[22:0]} * {1'b1, x2[22:0]};
    end

    ////////////////////////////////////////
    // Stage 2: one-place normalize
    ////////////////////////////////////////
    logic               s2_sign;
    logic               s2_zero;
    logic signed [10:0] s2_exp;
    logic [46:0]        s2_norm;

    // Product of two 1.x values lies in [1,4)
    always_ff @(posedge clk) begin
        s2_sign <= s1_sign;
        s2_zero <= s1_zero;
        s2_exp  <= $signed({1'b0, s1_exp}) - 11'sd127 + $signed({10'd0, s1_prod[47]});
        s2_norm <= s1_prod[47] ? s1_prod[46:0] : {s1_prod[45:0], 1'b0};
    end

    ////////////////////////////////////////
    // Stage 3: truncate, range check, pack
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            y <= '0;
        end else if (s2_zero || s2_exp <= 0) begin
            y <= {s2_sign, 31'd0};
        end else if (s2_exp >= 255) begin
            y <= {s2_sign, 8'hff, 23'd0};
        end else begin
            y <= {s2_sign, s2_exp[7:0], s2_norm[46:24]};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fpu_pkg.sv ====
////////////////////////////////////////
// FPU shared types and constants
// Operation codes, request/response, latencies
////////////////////////////////////////
`default_nettype none

package fpu_pkg;

    // Operation codes, same numbering as the core decoder
    typedef enum logic [3:0] {
        FADD     = 4'd0,
        FSUB     = 4'd1,
        FMUL     = 4'd2,
        FDIV     = 4'd3,
        FSQRT    = 4'd4,
        FSGNJ    = 4'd5,
        FSGNJN   = 4'd6,
        FSGNJX   = 4'd7,
        FEQ      = 4'd8,
        FLE      = 4'd9,
        FLT      = 4'd10,
        FCVT_W_S = 4'd11,
        FCVT_S_W = 4'd12
    } fpu_op_t;

    typedef struct packed {
        fpu_op_t     op;
        logic [31:0] src0;
        logic [31:0] src1;
    } fpu_req_t;

    typedef struct packed {
        logic [31:0] result;
    } fpu_resp_t;

    // Cycles from operands held to registered datapath result
    localparam int unsigned LAT_PIPE = 3;
    localparam int unsigned LAT_MISC = 1;

    function automatic int unsigned fpu_latency(fpu_op_t op);
        case (op)
            FADD, FSUB, FMUL: return LAT_PIPE;
            default:          return LAT_MISC;
        endcase
    endfunction

    // Leading zero count, 32 for an all-zero word
    function automatic logic [5:0] fpu_lzc(logic [31:0] v);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                n = 6'(31 - i);
            end
        end
        return n;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/fpu_top.sv ====
////////////////////////////////////////
// FPU top level
// Control, latency timer and three datapaths
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    input  fpu_pkg::fpu_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    output fpu_pkg::fpu_resp_t resp
);
    import fpu_pkg::*;

    localparam int CNT_W = 4;

    fpu_op_t          op;
    logic [31:0]      src0;
    logic [31:0]      src1;
    logic             tmr_load;
    logic [CNT_W-1:0] tmr_count;
    logic             tmr_expire;
    logic [31:0]      addsub_res;
    logic [31:0]      mul_res;
    logic [31:0]      misc_res;

    fpu_ctrl #(.CNT_W(CNT_W)) u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .op         (op),
        .src0       (src0),
        .src1       (src1),
        .tmr_load   (tmr_load),
        .tmr_count  (tmr_count),
        .tmr_expire (tmr_expire),
        .addsub_res (addsub_res),
        .mul_res    (mul_res),
        .misc_res   (misc_res),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    fpu_latency_timer #(.CNT_W(CNT_W)) u_timer (
        .clk     (clk),
        .rstn    (rstn),
        .load    (tmr_load),
        .count   (tmr_count),
        .expire  (tmr_expire),
        .running ()
    );

    // Datapaths run every cycle on the held operands
    fpu_addsub u_addsub (
        .clk  (clk),
        .rstn (rstn),
        .sub  (op == FSUB),
        .x1   (src0),
        .x2   (src1),
        .y    (addsub_res)
    );

    fpu_mul u_mul (
        .clk  (clk),
        .rstn (rstn),
        .x1   (src0),
        .x2   (src1),
        .y    (mul_res)
    );

    fpu_misc u_misc (
        .clk  (clk),
        .rstn (rstn),
        .op   (op),
        .x1   (src0),
        .x2   (src1),
        .y    (misc_res)
    );

endmodule

`default_nettype wire

// ==== verification/fpu_checker.sv ====
////////////////////////////////////////
// FPU response checker
// Tracks accepted requests, checks value and latency
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_checker (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    input  logic               req_ready,
    input  logic               resp_valid,
    input  fpu_pkg::fpu_resp_t resp,
    input  int                 test_id,
    input  logic [31:0]        exp_result,
    input  int                 exp_lat,
    output int                 err_count,
    output int                 done_count,
    output int                 pending
);

    typedef struct packed {
        logic [15:0] id;
        logic [31:0] result;
        logic [7:0]  lat;
        logic [31:0] cyc;
    } expect_t;

    expect_t     exp_q[$];
    expect_t     head;
    logic [31:0] cyc;
    logic        reset_seen;

    initial begin
        err_count  = 0;
        done_count = 0;
        pending    = 0;
        cyc        = '0;
        reset_seen = 1'b0;
    end

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want, input int id);
        $display("Fail at %0d ns: %s = %h, expected %h (test %0d)",
                 $time, name, got, want, id);
        err_count++;
    endtask

    task automatic check_reset();
        int errs;
        errs = err_count;
        if (req_ready !== 1'b1) flag_mismatch("req_ready", req_ready, 1, 0);
        if (resp_valid !== 1'b0) flag_mismatch("resp_valid", resp_valid, 0, 0);
        if (resp.result !== 32'd0) flag_mismatch("resp.result", resp.result, 0, 0);
        if (errs == err_count) $display("test 0 passed: reset state");
        done_count++;
    endtask

    // Latency counts from the accept edge to the edge that raises resp_valid
    task automatic check_response(input expect_t e);
        int errs;
        int lat;
        errs = err_count;
        lat  = int'(cyc - e.cyc) - 1;
        if (resp.result !== e.result) flag_mismatch("resp.result", resp.result, e.result, e.id);
        if (lat != int'(e.lat)) flag_mismatch("latency", lat, e.lat, e.id);
        if (errs == err_count) begin
            $display("test %0d passed: result %h after %0d cycles", e.id, resp.result, lat);
        end
        done_count++;
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rstn && !reset_seen) begin
            reset_seen = 1'b1;
            check_reset();
        end
        if (rstn && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0d ns: a response came with no request outstanding",
                         $time);
                err_count++;
            end else begin
                head = exp_q.pop_front();
                check_response(head);
            end
        end else if (rstn && exp_q.size() != 0 && req_ready) begin
            flag_mismatch("req_ready", req_ready, 0, exp_q[0].id);
        end
        // New request is queued after the response that ends on the same edge
        if (rstn && req_valid && req_ready) begin
            exp_q.push_back({16'(test_id), exp_result, 8'(exp_lat), cyc});
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== verification/fpu_clk_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/fpu_tb.sv ====
////////////////////////////////////////
// FPU testbench top
// Table of operations driven through the DUT
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
    import fpu_pkg::*;

    typedef struct packed {
        fpu_op_t     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic [3:0]  lat;
    } vec_t;

    localparam int NUM_VECS    = 20;
    localparam int WAIT_LIMIT  = 50;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    logic        req_ready;
    logic        resp_valid;
    fpu_req_t    req;
    fpu_resp_t   resp;
    int          test_id;
    logic [31:0] exp_result;
    int          exp_lat;
    int          err_count;
    int          done_count;
    int          pending;
    int          seed;
    int          gap;
    vec_t        vecs [NUM_VECS];

    fpu_clk_gen #(.PERIOD(20), .RST_CYCLES(4)) u_clk (.clk(clk), .rstn(rstn));

    fpu_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    fpu_checker u_checker (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .test_id    (test_id),
        .exp_result (exp_result),
        .exp_lat    (exp_lat),
        .err_count  (err_count),
        .done_count (done_count),
        .pending    (pending)
    );

    ////////////////////////////////////////
    // Stimulus table, values exact under truncation
    ////////////////////////////////////////
    task automatic load_table();
        vecs[0]  = '{FADD,     32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000, 4'd4};
        vecs[1]  = '{FSUB,     32'h4040_0000, 32'h4040_0000, 32'h0000_0000, 4'd4};
        vecs[2]  = '{FADD,     32'hc000_0000, 32'h3f00_0000, 32'hbfc0_0000, 4'd4};
        vecs[3]  = '{FSUB,     32'h3f80_0000, 32'h3f40_0000, 32'h3e80_0000, 4'd4};
        vecs[4]  = '{FMUL,     32'h3fc0_0000, 32'hc080_0000, 32'hc0c0_0000, 4'd4};
        vecs[5]  = '{FMUL,     32'h7f00_0000, 32'h7f00_0000, 32'h7f80_0000, 4'd4};
        vecs[6]  = '{FSGNJ,    32'h3fc0_0000, 32'hc000_0000, 32'hbfc0_0000, 4'd2};
        vecs[7]  = '{FSGNJN,   32'h3fc0_0000, 32'hc000_0000, 32'h3fc0_0000, 4'd2};
        vecs[8]  = '{FSGNJX,   32'hbfc0_0000, 32'hc000_0000, 32'h3fc0_0000, 4'd2};
        vecs[9]  = '{FEQ,      32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 4'd2};
        vecs[10] = '{FLT,      32'hbf80_0000, 32'h3f00_0000, 32'h0000_0001, 4'd2};
        vecs[11] = '{FLT,      32'h3f00_0000, 32'hbf80_0000, 32'h0000_0000, 4'd2};
        vecs[12] = '{FLE,      32'h4000_0000, 32'hc040_0000, 32'h0000_0000, 4'd2};
        vecs[13] = '{FLE,      32'hbf80_0000, 32'hbf80_0000, 32'h0000_0001, 4'd2};
        vecs[14] = '{FCVT_W_S, 32'hc0f8_0000, 32'h0000_0000, 32'hffff_fff9, 4'd2};
        vecs[15] = '{FCVT_S_W, 32'h0000_000c, 32'h0000_0000, 32'h4140_0000, 4'd2};
        vecs[16] = '{FDIV,     32'h4000_0000, 32'h3f80_0000, 32'h0000_0000, 4'd2};
        vecs[17] = '{FSQRT,    32'h4080_0000, 32'h0000_0000, 32'h0000_0000, 4'd2};
        vecs[18] = '{FADD,     32'h4000_0000, 32'h4000_0000, 32'h4080_0000, 4'd4};
        vecs[19] = '{FMUL,     32'h4040_0000, 32'h3f00_0000, 32'h3fc0_0000, 4'd4};
    endtask

    task automatic report_stall(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (rstn !== 1'b1) begin
            if (waited == WAIT_LIMIT) report_stall("reset was never released");
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
    endtask

    // Drive on the falling edge, req_ready is stable there
    task automatic issue_request(input int idx);
        int waited;
        waited     = 0;
        req_valid  = 1'b1;
        req.op     = vecs[idx].op;
        req.src0   = vecs[idx].a;
        req.src1   = vecs[idx].b;
        test_id    = idx + 1;
        exp_result = vecs[idx].result;
        exp_lat    = int'(vecs[idx].lat);
        while (req_ready !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                report_stall($sformatf("request of test %0d was never accepted", idx + 1));
            end
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending != 0) begin
            if (waited == WAIT_LIMIT) report_stall("responses still missing at the end");
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
    endtask

    initial begin
        seed       = 68726;
        req_valid  = 1'b0;
        req        = '0;
        test_id    = 0;
        exp_result = '0;
        exp_lat    = 0;
        load_table();
        wait_reset();
        for (int i = 0; i < NUM_VECS; i++) begin
            // Gap of zero keeps the request waiting for the next ready cycle
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
            issue_request(i);
        end
        wait_drain();
        $display("Tests done: %0d of %0d, errors: %0d", done_count, NUM_VECS + 1, err_count);
        if (err_count == 0 && done_count == NUM_VECS + 1) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
